// ==== src/hsid_params.svh ====
`ifndef HSID_PARAMS_SVH
`define HSID_PARAMS_SVH

`define HSID_SAMPLE_W    16      // Unsigned spectral sample
`define HSID_MSE_W       32      // Finished MSE value
`define HSID_BANDS       16      // Bands per spectrum
`define HSID_BANDS_LOG2  4       // Mean shift
`define HSID_LIB_SIZE    16      // Reference spectra in library
`define HSID_REF_W       4       // Reference index
`define HSID_BAND_W      4       // Band index
`define HSID_ACC_W       36      // Sum of 16 squares of 16-bit values
`define HSID_ADDR_W      12      // AXI4-Lite byte address
`define HSID_DATA_W      32      // AXI4-Lite data bus

`define HSID_REG_CTRL      12'h000  // bit0 start, bit1 clear
`define HSID_REG_STATUS    12'h004  // bit0 busy, bit1 done
`define HSID_REG_NUM_REFS  12'h008
`define HSID_REG_MIN_VALUE 12'h010
`define HSID_REG_MIN_REF   12'h014
`define HSID_REG_MAX_VALUE 12'h018
`define HSID_REG_MAX_REF   12'h01C
`define HSID_REG_MIN_UPD   12'h020
`define HSID_REG_MAX_UPD   12'h024
`define HSID_REG_PIXEL     12'h040  // One word per band
`define HSID_REG_LIB       12'h400  // Word index is ref*16+band

`endif

// ==== src/hsid_pkg.sv ====
`include "hsid_params.svh"

package hsid_pkg;

  typedef enum logic [1:0] {
    IDLE,   // Waiting for start
    SCAN,   // Issuing bands
    DRAIN   // Waiting for last result
  } hsid_ctrl_state_e;

  typedef struct packed {
    logic                    valid;
    logic [`HSID_REF_W-1:0]  ref_idx;   // Reference being streamed
    logic [`HSID_BAND_W-1:0] band;
    logic                    first;     // Band 0 of a reference
    logic                    last;      // Final band of final reference
  } hsid_band_t;

  typedef struct packed {
    logic                    valid;
    logic [`HSID_MSE_W-1:0]  value;
    logic [`HSID_REF_W-1:0]  ref_idx;
    logic                    last;
  } hsid_mse_t;

  typedef struct packed {
    logic                    valid;
    logic                    last;
    logic [`HSID_MSE_W-1:0]  min_value;
    logic [`HSID_REF_W-1:0]  min_ref;
    logic                    min_changed;
    logic [`HSID_MSE_W-1:0]  max_value;
    logic [`HSID_REF_W-1:0]  max_ref;
    logic                    max_changed;
  } hsid_extreme_t;

  typedef struct packed {
    logic                                 en;
    logic [`HSID_REF_W+`HSID_BAND_W-1:0]  addr;  // ref*16+band
    logic [`HSID_SAMPLE_W-1:0]            data;
  } hsid_lib_wr_t;

endpackage

// ==== src/hsid_axil_regs.sv ====
`timescale 1ns/1ps
`include "hsid_params.svh"

module hsid_axil_regs (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [`HSID_ADDR_W-1:0]                awaddr,
  input  logic                                   awvalid,
  output logic                                   awready,
  input  logic [`HSID_DATA_W-1:0]                wdata,
  input  logic [`HSID_DATA_W/8-1:0]              wstrb,
  input  logic                                   wvalid,
  output logic                                   wready,
  output logic [1:0]                             bresp,
  output logic                                   bvalid,
  input  logic                                   bready,
  input  logic [`HSID_ADDR_W-1:0]                araddr,
  input  logic                                   arvalid,
  output logic                                   arready,
  output logic [`HSID_DATA_W-1:0]                rdata,
  output logic [1:0]                             rresp,
  output logic                                   rvalid,
  input  logic                                   rready,
  output hsid_pkg::hsid_lib_wr_t                 lib_wr,
  output logic [`HSID_BANDS*`HSID_SAMPLE_W-1:0]  pixel,     // Band b at bits [16b +: 16]
  output logic [`HSID_DATA_W-1:0]                num_refs,
  output logic                                   start,     // One-cycle pulse
  output logic                                   busy,
  input  hsid_pkg::hsid_extreme_t                extreme
);

  logic [`HSID_BANDS-1:0][`HSID_SAMPLE_W-1:0] pixel_q;
  logic                          wr_hs, rd_hs;        // AXI handshakes
  logic                          wr_ctrl, wr_pix, wr_lib, rd_pix;
  logic                          host_clear;
  logic                          done;
  logic [`HSID_MSE_W-1:0]        min_value, max_value;
  logic [`HSID_REF_W-1:0]        min_ref, max_ref;
  logic [`HSID_REF_W:0]          min_upd, max_upd;    // Up to 16 updates per scan
  logic [`HSID_DATA_W-1:0]       rd_word;

  assign awready = ~bvalid;                           // One write outstanding
  assign wready  = ~bvalid;
  assign wr_hs   = awvalid & wvalid & ~bvalid;
  assign arready = ~rvalid;
  assign rd_hs   = arvalid & ~rvalid;
  assign bresp   = 2'b00;                             // Always OKAY
  assign rresp   = 2'b00;

  // Write decode
  always_comb begin
    wr_ctrl = wr_hs && (awaddr == `HSID_REG_CTRL) && wstrb[0];
    wr_pix  = wr_hs && !busy && (awaddr >= `HSID_REG_PIXEL)
              && (awaddr < `HSID_REG_PIXEL + 4 * `HSID_BANDS);
    wr_lib  = wr_hs && !busy && (awaddr >= `HSID_REG_LIB)
              && (awaddr < `HSID_REG_LIB + 4 * `HSID_BANDS * `HSID_LIB_SIZE);
    rd_pix  = (araddr >= `HSID_REG_PIXEL) && (araddr < `HSID_REG_PIXEL + 4 * `HSID_BANDS);
  end

  assign start      = wr_ctrl & wdata[0] & ~busy;     // Ignored while scanning
  assign host_clear = wr_ctrl & wdata[1];
  assign pixel      = pixel_q;

  // Library base is 1 KiB aligned so address bits [9:2] give ref*16+band
  assign lib_wr.en   = wr_lib & (&wstrb[1:0]);       // Full sample writes only
  assign lib_wr.addr = awaddr[2 +: `HSID_REF_W+`HSID_BAND_W];
  assign lib_wr.data = wdata[`HSID_SAMPLE_W-1:0];

  // Config registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pixel_q  <= '0;
      num_refs <= '0;
    end else begin
      if (wr_pix) begin                               // 64-byte aligned base
        if (wstrb[0]) pixel_q[awaddr[2 +: `HSID_BAND_W]][7:0]  <= wdata[7:0];
        if (wstrb[1]) pixel_q[awaddr[2 +: `HSID_BAND_W]][15:8] <= wdata[15:8];
      end
      if (wr_hs && awaddr == `HSID_REG_NUM_REFS) begin
        for (int i = 0; i < `HSID_DATA_W/8; i++) begin
          if (wstrb[i]) num_refs[8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // Busy and done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      if (host_clear) done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (extreme.valid && extreme.last) begin
        busy <= 1'b0;                                 // Last comparator output seen
        done <= 1'b1;
      end
    end
  end

  // Result registers and update counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      min_value <= '1;
      min_ref   <= '0;
      max_value <= '0;
      max_ref   <= '0;
      min_upd   <= '0;
      max_upd   <= '0;
    end else begin
      if (host_clear) begin
        min_value <= '1;
        min_ref   <= '0;
        max_value <= '0;
        max_ref   <= '0;
      end else if (extreme.valid) begin
        min_value <= extreme.min_value;
        min_ref   <= extreme.min_ref;
        max_value <= extreme.max_value;
        max_ref   <= extreme.max_ref;
      end
      if (host_clear || start) begin
        min_upd <= '0;
        max_upd <= '0;
      end else begin
        if (extreme.min_changed) min_upd <= min_upd + 1'b1;  // Flags only high with valid
        if (extreme.max_changed) max_upd <= max_upd + 1'b1;
      end
    end
  end

  // Read mux
  always_comb begin
    rd_word = '0;
    if (rd_pix) begin
      rd_word[`HSID_SAMPLE_W-1:0] = pixel_q[araddr[2 +: `HSID_BAND_W]];
    end else begin
      case (araddr)
        `HSID_REG_STATUS:    rd_word[1:0] = {done, busy};
        `HSID_REG_NUM_REFS:  rd_word = num_refs;
        `HSID_REG_MIN_VALUE: rd_word = min_value;
        `HSID_REG_MIN_REF:   rd_word[`HSID_REF_W-1:0] = min_ref;
        `HSID_REG_MAX_VALUE: rd_word = max_value;
        `HSID_REG_MAX_REF:   rd_word[`HSID_REF_W-1:0] = max_ref;
        `HSID_REG_MIN_UPD:   rd_word[`HSID_REF_W:0] = min_upd;
        `HSID_REG_MAX_UPD:   rd_word[`HSID_REF_W:0] = max_upd;
        default:             rd_word = '0;           // CTRL, library and unmapped
      endcase
    end
  end

  // Response channels
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_hs) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (rd_hs) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hs) rdata <= rd_word;                      // Held until rready
  end

endmodule

// ==== src/hsid_library_ram.sv ====
`timescale 1ns/1ps
`include "hsid_params.svh"

module hsid_library_ram (
  input  logic                                  clk,
  input  hsid_pkg::hsid_lib_wr_t                lib_wr,
  input  logic [`HSID_REF_W+`HSID_BAND_W-1:0]   rd_addr,   // ref*16+band
  output logic [`HSID_SAMPLE_W-1:0]             rd_data
);

  localparam int depth = `HSID_LIB_SIZE * `HSID_BANDS;

  logic [`HSID_SAMPLE_W-1:0] mem [depth];   // 256 x 16

  // Host write port
  always_ff @(posedge clk) begin
    if (lib_wr.en) begin
      mem[lib_wr.addr] <= lib_wr.data;
    end
  end

  // Registered read, one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== src/hsid_ctrl.sv ====
`timescale 1ns/1ps
`include "hsid_params.svh"

module hsid_ctrl (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  start,
  input  logic [`HSID_DATA_W-1:0]               num_refs,
  input  logic                                  busy,
  output hsid_pkg::hsid_band_t                  band,
  output logic [`HSID_REF_W+`HSID_BAND_W-1:0]   rd_addr,
  output logic                                  clear    // Comparator restart
);

  hsid_pkg::hsid_ctrl_state_e state_q;
  logic                       launch;
  logic [`HSID_REF_W-1:0]     last_ref_d, last_ref_q;
  logic [`HSID_BAND_W-1:0]    next_band;
  logic [`HSID_REF_W-1:0]     next_ref;

  // Clamp reference count to 1..16
  always_comb begin
    if (num_refs == '0) last_ref_d = '0;
    else if (num_refs >= `HSID_LIB_SIZE) last_ref_d = '1;
    else last_ref_d = num_refs[`HSID_REF_W-1:0] - 1'b1;
  end

  // DRAIN with busy low is the last cycle of a scan and may relaunch
  assign launch = start && (state_q == hsid_pkg::IDLE
                  || (state_q == hsid_pkg::DRAIN && !busy));
  assign clear  = launch;

  // Band count is a power of two so the band counter wraps by itself
  assign next_band = band.band + 1'b1;
  assign next_ref  = (band.band == `HSID_BANDS - 1) ? band.ref_idx + 1'b1 : band.ref_idx;

  assign rd_addr = {band.ref_idx, band.band};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= hsid_pkg::IDLE;
      band       <= '0;
      last_ref_q <= '0;
    end else if (launch) begin
      state_q    <= hsid_pkg::SCAN;
      last_ref_q <= last_ref_d;                        // Held for whole scan
      band       <= '{valid: 1'b1, ref_idx: '0, band: '0, first: 1'b1, last: 1'b0};
    end else begin
      case (state_q)
        hsid_pkg::SCAN: begin
          if (band.last) begin
            band.valid <= 1'b0;
            band.last  <= 1'b0;
            state_q    <= hsid_pkg::DRAIN;
          end else begin
            band.band    <= next_band;
            band.ref_idx <= next_ref;
            band.first   <= (next_band == '0);
            band.last    <= (next_band == `HSID_BANDS - 1) && (next_ref == last_ref_q);
          end
        end
        hsid_pkg::DRAIN: if (!busy) state_q <= hsid_pkg::IDLE;
        default: ;                                     // IDLE waits for start
      endcase
    end
  end

endmodule

// ==== src/hsid_mse_unit.sv ====
`timescale 1ns/1ps
`include "hsid_params.svh"

module hsid_mse_unit (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  hsid_pkg::hsid_band_t                  band,
  input  logic [`HSID_SAMPLE_W-1:0]             lib_sample,  // RAM data, one cycle after band
  input  logic [`HSID_BANDS*`HSID_SAMPLE_W-1:0] pixel,
  output hsid_pkg::hsid_mse_t                   mse
);

  hsid_pkg::hsid_band_t          band_d;    // Aligned with lib_sample
  hsid_pkg::hsid_band_t          band_sq;   // Aligned with sq_q
  logic [`HSID_SAMPLE_W-1:0]     pix_sample;
  logic [`HSID_SAMPLE_W-1:0]     diff;
  logic [2*`HSID_SAMPLE_W-1:0]   sq_q;
  logic [`HSID_ACC_W-1:0]        acc_q;
  logic [`HSID_ACC_W-1:0]        acc_sum;

  // Stage 1 compare
  always_comb begin
    pix_sample = pixel[band_d.band*`HSID_SAMPLE_W +: `HSID_SAMPLE_W];
    if (pix_sample >= lib_sample) diff = pix_sample - lib_sample;
    else diff = lib_sample - pix_sample;                 // Absolute difference
  end

  // Stage 3 sum including current square
  always_comb begin
    if (band_sq.first) begin
      acc_sum = {{(`HSID_ACC_W-2*`HSID_SAMPLE_W){1'b0}}, sq_q};  // New reference
    end else begin
      acc_sum = acc_q + sq_q;
    end
  end

  // Control path
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      band_d  <= '0;
      band_sq <= '0;
      mse     <= '0;
    end else begin
      band_d        <= band;
      band_sq       <= band_d;
      mse.valid     <= band_sq.valid && (band_sq.band == `HSID_BANDS - 1);
      mse.value     <= acc_sum[`HSID_ACC_W-1:`HSID_BANDS_LOG2];   // Divide by band count
      mse.ref_idx   <= band_sq.ref_idx;
      mse.last      <= band_sq.valid && band_sq.last;
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    sq_q <= diff * diff;
    if (band_sq.valid) acc_q <= acc_sum;
  end

endmodule

// ==== src/hsid_mse_comp.sv ====
`timescale 1ns/1ps
`include "hsid_params.svh"

module hsid_mse_comp (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    clear,     // Start of a new scan
  input  hsid_pkg::hsid_mse_t     mse,
  output hsid_pkg::hsid_extreme_t extreme
);

  localparam hsid_pkg::hsid_extreme_t extreme_init = '{
    valid:       1'b0,
    last:        1'b0,
    min_value:   '1,         // Any MSE beats it
    min_ref:     '0,
    min_changed: 1'b0,
    max_value:   '0,
    max_ref:     '0,
    max_changed: 1'b0
  };

  logic min_hit, max_hit;

  // Ties replace so the later reference wins
  assign min_hit = mse.valid && (mse.value <= extreme.min_value);
  assign max_hit = mse.valid && (mse.value >= extreme.max_value);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      extreme <= extreme_init;
    end else if (clear) begin
      extreme <= extreme_init;
    end else begin
      extreme.valid       <= mse.valid;
      extreme.last        <= mse.valid && mse.last;   // Forwarded end of scan
      extreme.min_changed <= min_hit;
      extreme.max_changed <= max_hit;
      if (min_hit) begin
        extreme.min_value <= mse.value;
        extreme.min_ref   <= mse.ref_idx;
      end
      if (max_hit) begin
        extreme.max_value <= mse.value;
        extreme.max_ref   <= mse.ref_idx;
      end
    end
  end

endmodule

// ==== src/hsid_top.sv ====
`timescale 1ns/1ps
`include "hsid_params.svh"

module hsid_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`HSID_ADDR_W-1:0]    awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [`HSID_DATA_W-1:0]    wdata,
  input  logic [`HSID_DATA_W/8-1:0]  wstrb,
  input  logic                       wvalid,
  output logic                       wready,
  output logic [1:0]                 bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  logic [`HSID_ADDR_W-1:0]    araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [`HSID_DATA_W-1:0]    rdata,
  output logic [1:0]                 rresp,
  output logic                       rvalid,
  input  logic                       rready
);

  hsid_pkg::hsid_lib_wr_t                  lib_wr;
  logic [`HSID_BANDS*`HSID_SAMPLE_W-1:0]   pixel;
  logic [`HSID_DATA_W-1:0]                 num_refs;
  logic                                    start, busy, clear;
  hsid_pkg::hsid_band_t                    band;
  logic [`HSID_REF_W+`HSID_BAND_W-1:0]     rd_addr;
  logic [`HSID_SAMPLE_W-1:0]               lib_sample;
  hsid_pkg::hsid_mse_t                     mse;
  hsid_pkg::hsid_extreme_t                 extreme;

  hsid_axil_regs u_regs (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .lib_wr, .pixel, .num_refs, .start, .busy, .extreme
  );

  hsid_library_ram u_ram (
    .clk, .lib_wr, .rd_addr, .rd_data(lib_sample)
  );

  hsid_ctrl u_ctrl (
    .clk, .rst_n, .start, .num_refs, .busy, .band, .rd_addr, .clear
  );

  hsid_mse_unit u_mse (
    .clk, .rst_n, .band, .lib_sample, .pixel, .mse
  );

  hsid_mse_comp u_comp (
    .clk, .rst_n, .clear, .mse, .extreme
  );

endmodule

// ==== bench/hsid_tb.sv ====
`timescale 1ns/1ps
`include "hsid_params.svh"

module hsid_tb;

  localparam int timeout_cycles = 200;                     // Per handshake loop
  localparam int poll_limit     = 300;                     // STATUS reads per scan
  localparam int n_words        = `HSID_LIB_SIZE * `HSID_BANDS;

  logic                        clk, rst_n;
  logic [`HSID_ADDR_W-1:0]     awaddr, araddr;
  logic                        awvalid, wvalid, bready, arvalid, rready;
  logic [`HSID_DATA_W-1:0]     wdata, rdata;
  logic [`HSID_DATA_W/8-1:0]   wstrb;
  logic                        awready, wready, bvalid, arready, rvalid;
  logic [1:0]                  bresp, rresp;

  logic [31:0] lfsr = 32'h99d2_d423;
  logic [15:0] pix_m [`HSID_BANDS];                        // Host copy of pixel
  logic [15:0] lib_m [n_words];                            // Host copy of library
  logic [31:0] exp_min, exp_max, exp_min_ref, exp_max_ref, exp_min_upd, exp_max_upd;
  string       name_q[$];                                  // Pending compares
  logic [31:0] got_q[$], want_q[$];
  int          checks = 0, errors = 0, test_errors = 0, test_num = 0;
  int          cyc = 0;

  hsid_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                                 // 4 ns period
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    #1_000_000;                                            // Whole-run guard
    $display("Simulation ran out of time before all tests finished");
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);  // Galois taps 32,30,26,25
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};                         // One step per bit
      lfsr = lfsr_next(lfsr);
    end
    return val;
  endfunction

  // Expected scan result from host copies
  function automatic void model_scan(input int num);
    logic [35:0] sum;
    logic [31:0] mse;
    logic [15:0] d;
    int          n;
    n = (num < 1) ? 1 : ((num > 16) ? 16 : num);           // Clamp to 1..16
    exp_min     = '1;
    exp_max     = '0;
    exp_min_ref = '0;
    exp_max_ref = '0;
    exp_min_upd = '0;
    exp_max_upd = '0;
    for (int r = 0; r < n; r++) begin
      sum = '0;
      for (int b = 0; b < 16; b++) begin
        d   = (pix_m[b] > lib_m[r*16+b]) ? pix_m[b] - lib_m[r*16+b] : lib_m[r*16+b] - pix_m[b];
        sum = sum + d * d;
      end
      mse = sum >> 4;                                      // Mean over 16 bands
      if (mse <= exp_min) begin                            // Later ref wins ties
        exp_min     = mse;
        exp_min_ref = r;
        exp_min_upd++;
      end
      if (mse >= exp_max) begin
        exp_max     = mse;
        exp_max_ref = r;
        exp_max_upd++;
      end
    end
  endfunction

  function automatic void expect_eq(input string name, input logic [31:0] got,
                                    input logic [31:0] want);
    name_q.push_back(name);
    got_q.push_back(got);
    want_q.push_back(want);
  endfunction

  // Compare process
  initial begin : compare_proc
    string       nm;
    logic [31:0] g, w;
    forever begin
      @(negedge clk);
      while (name_q.size() > 0) begin
        nm = name_q.pop_front();
        g  = got_q.pop_front();
        w  = want_q.pop_front();
        checks++;
        assert (g === w) else begin
          $display("ERROR @ %0t ns: %s read %h, expected %h", $time, nm, g, w);
          errors++;
        end
      end
    end
  end

  task automatic report_timeout(input string what);
    $display("Timeout: DUT gave no %s within the allowed cycles at %0t ns", what, $time);
    errors++;
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
    int n;
    @(posedge clk);
    awaddr  <= addr[`HSID_ADDR_W-1:0];
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= '1;
    wvalid  <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!(awready && wready) && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (n >= timeout_cycles) report_timeout("write address/data accept");
    @(posedge clk);                                        // Handshake edge
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!bvalid && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (n >= timeout_cycles) report_timeout("write response");
    else expect_eq("BRESP", bresp, 2'b00);
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
    int n;
    @(posedge clk);
    araddr  <= addr[`HSID_ADDR_W-1:0];
    arvalid <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!arready && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (n >= timeout_cycles) report_timeout("read address accept");
    @(posedge clk);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!rvalid && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (n >= timeout_cycles) report_timeout("read data");
    else expect_eq("RRESP", rresp, 2'b00);
    data = rdata;                                          // Stable at negedge
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic read_check(input logic [31:0] addr, input string name,
                            input logic [31:0] want);
    logic [31:0] rd;
    axi_read(addr, rd);
    expect_eq(name, rd, want);
  endtask

  task automatic write_pixel(input int b, input logic [15:0] v);
    pix_m[b] = v;
    axi_write(`HSID_REG_PIXEL + 4 * b, {16'h0, v});
  endtask

  task automatic write_lib(input int r, input int b, input logic [15:0] v);
    lib_m[r*16+b] = v;
    axi_write(`HSID_REG_LIB + 4 * (r * 16 + b), {16'h0, v});
  endtask

  task automatic wait_done();
    logic [31:0] st;
    int          n;
    st = '0;
    n  = 0;
    while (!st[1] && n < poll_limit) begin
      axi_read(`HSID_REG_STATUS, st);
      n++;
    end
    if (!st[1]) report_timeout("done flag");
    else expect_eq("STATUS after scan", st, 32'h2);        // Done set, busy clear
  endtask

  task automatic check_results();
    read_check(`HSID_REG_MIN_VALUE, "MIN_VALUE", exp_min);
    read_check(`HSID_REG_MIN_REF, "MIN_REF", exp_min_ref);
    read_check(`HSID_REG_MAX_VALUE, "MAX_VALUE", exp_max);
    read_check(`HSID_REG_MAX_REF, "MAX_REF", exp_max_ref);
    read_check(`HSID_REG_MIN_UPD, "MIN_UPD", exp_min_upd);
    read_check(`HSID_REG_MAX_UPD, "MAX_UPD", exp_max_upd);
  endtask

  task automatic check_reset_values();
    read_check(`HSID_REG_STATUS, "STATUS idle", 32'h0);
    read_check(`HSID_REG_MIN_VALUE, "MIN_VALUE idle", 32'hffff_ffff);
    read_check(`HSID_REG_MAX_VALUE, "MAX_VALUE idle", 32'h0);
    read_check(`HSID_REG_MIN_REF, "MIN_REF idle", 32'h0);
    read_check(`HSID_REG_MAX_REF, "MAX_REF idle", 32'h0);
    read_check(`HSID_REG_MIN_UPD, "MIN_UPD idle", 32'h0);
    read_check(`HSID_REG_MAX_UPD, "MAX_UPD idle", 32'h0);
  endtask

  task automatic run_scan(input int num);
    axi_write(`HSID_REG_NUM_REFS, num);
    model_scan(num);
    axi_write(`HSID_REG_CTRL, 32'h1);                      // Start pulse
    wait_done();
    check_results();
  endtask

  task automatic finish_test(input string name);
    int n;
    n = 0;
    while (name_q.size() > 0 && n < timeout_cycles) begin  // Let compares drain
      @(negedge clk);
      n++;
    end
    if (name_q.size() > 0) report_timeout("completion of pending compares");
    test_num++;
    $display("Test %0d %s: %s (%0d errors)", test_num, name,
             (errors == test_errors) ? "passed" : "failed", errors - test_errors);
    test_errors = errors;
  endtask

  initial begin : main_seq
    int t0, elapsed, mref;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    check_reset_values();
    read_check(12'h100, "unmapped read", 32'h0);
    axi_write(12'h100, 32'hdead_beef);                     // Dropped
    read_check(12'h100, "unmapped read after write", 32'h0);
    finish_test("reset values and unmapped access");

    for (int b = 0; b < 16; b++) write_pixel(b, rand_bits(16));
    for (int r = 0; r < 16; r++) begin
      for (int b = 0; b < 16; b++) write_lib(r, b, rand_bits(16));
    end
    run_scan(16);
    finish_test("full scan of 16 random references");

    for (int b = 0; b < 16; b++) begin
      write_lib(2, b, pix_m[b]);                           // Exact match
      write_lib(4, b, pix_m[b]);                           // Later duplicate of 2
      write_lib(1, b, pix_m[b][15] ? 16'h0000 : 16'hffff); // Farthest sample, largest MSE
      write_lib(3, b, lib_m[16+b]);                        // Duplicate of ref 1
    end
    run_scan(5);
    read_check(`HSID_REG_MIN_VALUE, "MIN_VALUE exact match", 32'h0);
    read_check(`HSID_REG_MIN_REF, "MIN_REF later duplicate", 32'h4);
    read_check(`HSID_REG_MAX_REF, "MAX_REF later duplicate", 32'h3);
    finish_test("reduced scan with match and duplicates");

    axi_write(`HSID_REG_NUM_REFS, 16);
    model_scan(16);
    mref = exp_min_ref;
    axi_write(`HSID_REG_CTRL, 32'h1);
    t0 = cyc;
    axi_write(`HSID_REG_PIXEL, {16'h0, ~pix_m[0]});        // Must be dropped
    axi_write(`HSID_REG_LIB + 4 * (mref * 16), {16'h0, ~lib_m[mref*16]});
    read_check(`HSID_REG_STATUS, "STATUS while busy", 32'h1);
    axi_write(`HSID_REG_CTRL, 32'h1);                      // Restart attempt
    wait_done();
    elapsed = cyc - t0;
    expect_eq("start to done within 16N+12 cycles", (elapsed <= 16 * 16 + 12), 1);
    check_results();
    read_check(`HSID_REG_PIXEL, "pixel band 0 after busy write", {16'h0, pix_m[0]});
    finish_test("start and writes while busy");

    for (int b = 0; b < 16; b++) write_pixel(b, rand_bits(16));
    run_scan(16);
    axi_write(`HSID_REG_CTRL, 32'h2);                      // Clear results
    check_reset_values();
    finish_test("rescan with new pixel and clear");

    $display("Summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+src
src/hsid_pkg.sv
src/hsid_axil_regs.sv
src/hsid_library_ram.sv
src/hsid_ctrl.sv
src/hsid_mse_unit.sv
src/hsid_mse_comp.sv
src/hsid_top.sv
bench/hsid_tb.sv

// ==== Bender.yml ====
package:
  name: hsid

export_include_dirs:
  - src

sources:
  - files:
      - src/hsid_pkg.sv
      - src/hsid_axil_regs.sv
      - src/hsid_library_ram.sv
      - src/hsid_ctrl.sv
      - src/hsid_mse_unit.sv
      - src/hsid_mse_comp.sv
      - src/hsid_top.sv
  - target: test
    files:
      - bench/hsid_tb.sv
